/* common/pe_cfg.svh */
// word, lane and sum widths for the PE slice; include wherever a width is needed
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// ==================================================
// operand word
// ==================================================
`define PE_DWD 16

// lane counts per precision
`define PE_N2B 8
`define PE_N4B 4

// ==================================================
// result
// ==================================================
// worst case is four 15*15 lanes, 900, and four -8*15 lanes, -480
`define PE_SUMWD 11

`endif

/* common/pe_arith_pkg.sv */
// arithmetic opcodes and result type, imported by the RTL and the testbench
`default_nettype none

`include "pe_cfg.svh"

package pe_arith_pkg;

    // precision of the dot product
    typedef enum logic [1:0] {
        XNOR = 2'd0,
        M1   = 2'd1,
        M2   = 2'd2,
        M4   = 2'd3
    } au_mode_e;

    // per-operand number type
    typedef enum logic {
        UNSIGNED = 1'b0,
        SIGNED   = 1'b1
    } num_type_e;

    // one signed sum per word pair
    typedef logic signed [`PE_SUMWD-1:0] sum_t;

endpackage

`default_nettype wire

/* common/pe_pix_pkg.sv */
// pixel word and unpacked lane types shared by the unpack stages and the combiner
`default_nettype none

`include "pe_cfg.svh"

package pe_pix_pkg;

    // raw 16-bit pixel or weight word
    typedef logic [`PE_DWD-1:0] pix_word_t;

    // 2-bit lane after sign or zero extension, range -2..3
    typedef logic signed [2:0] lane2_val_t;
    typedef lane2_val_t lane2_t [`PE_N2B];

    // 4-bit lane after extension, range -8..15
    typedef logic signed [4:0] lane4_val_t;
    typedef lane4_val_t lane4_t [`PE_N4B];

endpackage

`default_nettype wire

/* common/pix_if.sv */
// one unpacked operand handed from an unpack stage to the combiner
`timescale 1ns/1ns
`default_nettype none

interface pix_if
    import pe_pix_pkg::*;
();

    logic      valid;
    logic      ready;

    // masked word, used as is by the 1-bit modes
    pix_word_t bits;

    // extended lanes for M2 and M4
    lane2_t    l2;
    lane4_t    l4;

    modport src (
        output valid,
        output bits,
        output l2,
        output l4,
        input  ready
    );

    modport dst (
        input  valid,
        input  bits,
        input  l2,
        input  l4,
        output ready
    );

endinterface

`default_nettype wire

/* hw/operand_unpack.sv */
// masks one operand word, extends its lanes and holds it in a one-entry valid/ready stage
`timescale 1ns/1ns
`default_nettype none

`include "pe_cfg.svh"

module operand_unpack
    import pe_arith_pkg::*;
    import pe_pix_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_en,

    input  wire logic      i_valid,
    output logic           o_ready,
    input  wire pix_word_t i_word,

    input  wire pix_word_t i_mask,
    input  wire num_type_e i_num,

    pix_if.src             o_pix
);

    pix_word_t masked;
    lane2_t    lane2;
    lane4_t    lane4;
    logic      is_signed;
    logic      load;

    // ==================================================
    // mask and unpack
    // ==================================================
    assign masked    = i_word & i_mask;
    assign is_signed = (i_num == SIGNED);

    // lane 0 sits in the low bits of the word
    always_comb begin
        for (int i = 0; i < `PE_N2B; i++) begin
            lane2[i] = {is_signed & masked[2*i+1], masked[2*i +: 2]};
        end
        for (int i = 0; i < `PE_N4B; i++) begin
            lane4[i] = {is_signed & masked[4*i+3], masked[4*i +: 4]};
        end
    end

    // ==================================================
    // one-entry stage
    // ==================================================
    // accept when empty or when the combiner drains us on this edge
    assign o_ready = i_en && (!o_pix.valid || o_pix.ready);
    assign load    = i_valid && o_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_pix.valid <= 1'b0;
        end else if (i_en) begin
            if (load) begin
                o_pix.valid <= 1'b1;
            end else if (o_pix.ready) begin
                o_pix.valid <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge i_clk) begin
        if (load) begin
            o_pix.bits <= masked;
            o_pix.l2   <= lane2;
            o_pix.l4   <= lane4;
        end
    end

endmodule

`default_nettype wire

/* aunit/aunit_addt.sv */
// signed adder tree, sign-extends NUM inputs of IWD bits and sums them to OWD bits
`timescale 1ns/1ns
`default_nettype none

module aunit_addt #(
    parameter int NUM = 16,
    parameter int IWD = 1,
    parameter int OWD = 5
) (
    input  wire logic signed [IWD-1:0] i_in [NUM],
    output logic signed [OWD-1:0]      o_out
);

    localparam int LVLS = $clog2(NUM);
    localparam int PAD  = 1 << LVLS;

    // heap layout, leaves from PAD-1 up, root at 0
    wire logic signed [OWD-1:0] node [2*PAD-1];

    for (genvar k = 0; k < PAD; k++) begin : g_leaf
        if (k < NUM) begin : g_in
            assign node[PAD-1+k] = OWD'(i_in[k]);
        end else begin : g_pad
            assign node[PAD-1+k] = '0;
        end
    end

    for (genvar k = 0; k < PAD-1; k++) begin : g_node
        assign node[k] = node[2*k+1] + node[2*k+2];
    end

    assign o_out = node[0];

endmodule

`default_nettype wire

/* aunit/aunit_mac.sv */
// joins the two operand streams, forms the mode's dot product and registers the sum
`timescale 1ns/1ns
`default_nettype none

`include "pe_cfg.svh"

module aunit_mac
    import pe_arith_pkg::*;
    import pe_pix_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_en,

    input  wire au_mode_e  i_mode,
    input  wire num_type_e i_inum,
    input  wire num_type_e i_wnum,

    pix_if.dst             i_ipix,
    pix_if.dst             i_wpix,

    output logic           o_sum_valid,
    input  wire logic      i_sum_ready,
    output sum_t           o_sum
);

    // tree widths per precision
    localparam int CNT_WD = 5;
    localparam int P2_WD  = 5;
    localparam int S2_WD  = 8;
    localparam int P4_WD  = 9;

    pix_word_t                 term_bits;
    logic signed [0:0]         term1 [`PE_DWD];
    logic signed [P2_WD-1:0]   prod2 [`PE_N2B];
    logic signed [P4_WD-1:0]   prod4 [`PE_N4B];

    logic signed [CNT_WD-1:0]  neg_cnt;
    logic signed [S2_WD-1:0]   sum2;
    sum_t                      sum4;
    sum_t                      pop_cnt;
    sum_t                      sum_sel;
    logic                      take;

    // ==================================================
    // per-bit terms and lane products
    // ==================================================
    assign term_bits = (i_mode == XNOR) ? ~(i_ipix.bits ^ i_wpix.bits)
                                        : (i_ipix.bits & i_wpix.bits);

    always_comb begin
        for (int i = 0; i < `PE_DWD; i++) begin
            term1[i] = term_bits[i];
        end
        for (int i = 0; i < `PE_N2B; i++) begin
            prod2[i] = i_ipix.l2[i] * i_wpix.l2[i];
        end
        for (int i = 0; i < `PE_N4B; i++) begin
            prod4[i] = i_ipix.l4[i] * i_wpix.l4[i];
        end
    end

    // a set 1-bit term reads as -1, so this tree gives minus the count
    aunit_addt #(.NUM(`PE_DWD), .IWD(1), .OWD(CNT_WD)) u_at1 (
        .i_in  (term1),
        .o_out (neg_cnt)
    );

    aunit_addt #(.NUM(`PE_N2B), .IWD(P2_WD), .OWD(S2_WD)) u_at2 (
        .i_in  (prod2),
        .o_out (sum2)
    );

    aunit_addt #(.NUM(`PE_N4B), .IWD(P4_WD), .OWD(`PE_SUMWD)) u_at4 (
        .i_in  (prod4),
        .o_out (sum4)
    );

    // ==================================================
    // mode select
    // ==================================================
    assign pop_cnt = -sum_t'(neg_cnt);

    always_comb begin
        case (i_mode)
            XNOR:    sum_sel = sum_t'(2 * pop_cnt - 16);
            // product sign is negative when the types differ
            M1:      sum_sel = (i_inum == i_wnum) ? pop_cnt : -pop_cnt;
            M2:      sum_sel = sum_t'(sum2);
            default: sum_sel = sum4;
        endcase
    end

    // ==================================================
    // output stage
    // ==================================================
    // both operands leave together, only when the output slot frees up
    assign take         = i_en && i_ipix.valid && i_wpix.valid
                          && (!o_sum_valid || i_sum_ready);
    assign i_ipix.ready = take;
    assign i_wpix.ready = take;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_sum_valid <= 1'b0;
            o_sum       <= '0;
        end else if (i_en) begin
            if (take) begin
                o_sum_valid <= 1'b1;
                o_sum       <= sum_sel;
            end else if (i_sum_ready) begin
                o_sum_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pe_top.sv */
// PE slice top, two operand unpack stages feeding the dot-product combiner
`timescale 1ns/1ns
`default_nettype none

module pe_top
    import pe_arith_pkg::*;
    import pe_pix_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_en,

    // configuration, stable while words are in flight
    input  wire au_mode_e  i_mode,
    input  wire num_type_e i_inum,
    input  wire num_type_e i_wnum,
    input  wire pix_word_t i_mask,

    input  wire logic      i_ipix_valid,
    output logic           o_ipix_ready,
    input  wire pix_word_t i_ipix,

    input  wire logic      i_wpix_valid,
    output logic           o_wpix_ready,
    input  wire pix_word_t i_wpix,

    output logic           o_sum_valid,
    input  wire logic      i_sum_ready,
    output sum_t           o_sum
);

    pix_if ipix_bus ();
    pix_if wpix_bus ();

    // ==================================================
    // operand paths
    // ==================================================
    operand_unpack u_ipix (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_valid (i_ipix_valid),
        .o_ready (o_ipix_ready),
        .i_word  (i_ipix),
        .i_mask  (i_mask),
        .i_num   (i_inum),
        .o_pix   (ipix_bus.src)
    );

    operand_unpack u_wpix (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_valid (i_wpix_valid),
        .o_ready (o_wpix_ready),
        .i_word  (i_wpix),
        .i_mask  (i_mask),
        .i_num   (i_wnum),
        .o_pix   (wpix_bus.src)
    );

    // combiner
    aunit_mac u_mac (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_en        (i_en),
        .i_mode      (i_mode),
        .i_inum      (i_inum),
        .i_wnum      (i_wnum),
        .i_ipix      (ipix_bus.dst),
        .i_wpix      (wpix_bus.dst),
        .o_sum_valid (o_sum_valid),
        .i_sum_ready (i_sum_ready),
        .o_sum       (o_sum)
    );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
// free-running testbench clock, instantiated by the testbench top with its period
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 8
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_pe_top.sv */
// testbench for pe_top, random traffic in every mode checked against a dot-product model
`timescale 1ns/1ns
`default_nettype none

module tb_pe_top
    import pe_arith_pkg::*;
();

    localparam int WORDS   = 24;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        i_rst_n;
    logic        i_en;
    au_mode_e    i_mode;
    num_type_e   i_inum;
    num_type_e   i_wnum;
    logic [15:0] i_mask;
    logic        i_ipix_valid;
    logic        o_ipix_ready;
    logic [15:0] i_ipix;
    logic        i_wpix_valid;
    logic        o_wpix_ready;
    logic [15:0] i_wpix;
    logic        o_sum_valid;
    logic        i_sum_ready;
    sum_t        o_sum;

    // scoreboard state
    logic [15:0] ipq [$];
    logic [15:0] wpq [$];
    int          expq [$];
    int          n_ip;
    int          n_wp;
    int          n_out;
    int          pairs_sent;
    logic        ip_fire;
    logic        wp_fire;
    logic        out_fire;
    logic        pair_now;
    logic        pair_d1;
    logic        stall_on;
    logic        lat_chk;
    string       test_name;

    tb_clkgen #(.PERIOD(8)) u_clk (.o_clk(clk));

    pe_top dut0 (
        .i_clk        (clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_mode       (i_mode),
        .i_inum       (i_inum),
        .i_wnum       (i_wnum),
        .i_mask       (i_mask),
        .i_ipix_valid (i_ipix_valid),
        .o_ipix_ready (o_ipix_ready),
        .i_ipix       (i_ipix),
        .i_wpix_valid (i_wpix_valid),
        .o_wpix_ready (o_wpix_ready),
        .i_wpix       (i_wpix),
        .o_sum_valid  (o_sum_valid),
        .i_sum_ready  (i_sum_ready),
        .o_sum        (o_sum)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic describe_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        abort_run();
    endtask

    task automatic value_mismatch(input int exp, input int act);
        $display("FAILED %s expected %0d actual %0d", test_name, exp, act);
        abort_run();
    endtask

    // ==================================================
    // reference model
    // ==================================================
    // lane read as two's complement when its type is signed
    function automatic int lane_value(input int raw, input int width, input num_type_e nt);
        if (nt == SIGNED && raw >= (1 << (width - 1))) begin
            return raw - (1 << width);
        end
        return raw;
    endfunction

    function automatic int model_sum(input logic [15:0] a, input logic [15:0] b);
        logic [15:0] x;
        logic [15:0] y;
        int          acc;
        x   = a & i_mask;
        y   = b & i_mask;
        acc = 0;
        case (i_mode)
            XNOR: begin
                for (int i = 0; i < 16; i++) begin
                    acc += (x[i] == y[i]);
                end
                acc = 2 * acc - 16;
            end
            M1: begin
                for (int i = 0; i < 16; i++) begin
                    acc += (x[i] & y[i]);
                end
                if (i_inum != i_wnum) begin
                    acc = -acc;
                end
            end
            M2: begin
                for (int i = 0; i < 8; i++) begin
                    acc += lane_value(x[2*i +: 2], 2, i_inum) * lane_value(y[2*i +: 2], 2, i_wnum);
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    acc += lane_value(x[4*i +: 4], 4, i_inum) * lane_value(y[4*i +: 4], 4, i_wnum);
                end
            end
        endcase
        return acc;
    endfunction

    // ==================================================
    // monitor and scoreboard
    // ==================================================
    assign ip_fire  = i_ipix_valid && o_ipix_ready;
    assign wp_fire  = i_wpix_valid && o_wpix_ready;
    assign out_fire = o_sum_valid && i_sum_ready && i_en;
    // edge that carries the later transfer of a pair
    assign pair_now = (ip_fire && wp_fire) || (ip_fire && n_wp > n_ip)
                      || (wp_fire && n_ip > n_wp);

    always @(posedge clk) begin
        if (!i_rst_n) begin
            pair_d1 <= 1'b0;
        end else begin
            pair_d1 <= pair_now;
            if (out_fire) begin
                assert (expq.size() > 0) else describe_error("sum delivered with no pair pending");
                assert (int'(o_sum) == expq[0]) else value_mismatch(expq[0], int'(o_sum));
                void'(expq.pop_front());
                n_out <= n_out + 1;
            end
            if (ip_fire) begin
                ipq.push_back(i_ipix);
                n_ip <= n_ip + 1;
            end
            if (wp_fire) begin
                wpq.push_back(i_wpix);
                n_wp <= n_wp + 1;
            end
            // n-th pixel word pairs with n-th weight word
            if (ipq.size() > 0 && wpq.size() > 0) begin
                expq.push_back(model_sum(ipq.pop_front(), wpq.pop_front()));
            end
        end
    end

    a_reset: assert property (@(posedge clk) !i_rst_n |=> !o_sum_valid && o_sum == '0)
        else describe_error("output not cleared by reset");

    a_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_sum_valid && !(i_sum_ready && i_en) |=> o_sum_valid && $stable(o_sum))
        else describe_error("o_sum changed while the output was stalled");

    a_en_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_en |-> !o_ipix_ready && !o_wpix_ready)
        else describe_error("input ready high while i_en was low");

    a_en_freeze: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_en |=> $stable(o_sum_valid) && $stable(o_sum))
        else describe_error("output changed while i_en was low");

    // two cycles from the completing transfer to o_sum_valid
    a_lat_gap: assert property (@(posedge clk) disable iff (!i_rst_n)
        lat_chk && pair_now |=> !o_sum_valid)
        else describe_error("o_sum_valid rose one cycle after the pair");

    a_lat_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
        lat_chk && pair_d1 |=> o_sum_valid)
        else describe_error("o_sum_valid not high two cycles after the pair");

    // ==================================================
    // stimulus
    // ==================================================
    always @(negedge clk) begin
        if (stall_on) begin
            i_sum_ready = ($urandom_range(0, 2) != 0);
            i_en        = ($urandom_range(0, 7) != 0);
        end else begin
            i_sum_ready = 1'b1;
            i_en        = 1'b1;
        end
    end

    // first two words hit the 15*15 and -8*-8 corners
    function automatic logic [15:0] pick_word(input int k);
        logic [15:0] corner [4] = '{16'hffff, 16'h8888, 16'haaaa, 16'h7777};
        if (k < 2) begin
            return corner[k];
        end
        if ($urandom_range(0, 3) == 0) begin
            return corner[$urandom_range(0, 3)];
        end
        return 16'($urandom());
    endfunction

    task automatic drop_valid(input bit weight);
        if (weight) begin
            i_wpix_valid = 1'b0;
        end else begin
            i_ipix_valid = 1'b0;
        end
    endtask

    // returns on the edge that takes the word
    task automatic push_word(input bit weight, input logic [15:0] w);
        int t;
        @(negedge clk);
        if (weight) begin
            i_wpix_valid = 1'b1;
            i_wpix       = w;
        end else begin
            i_ipix_valid = 1'b1;
            i_ipix       = w;
        end
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) begin
                describe_error("input word never accepted");
            end
        end while (!(weight ? o_wpix_ready : o_ipix_ready));
    endtask

    task automatic stream_words(input bit weight, input int n);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(negedge clk);
                drop_valid(weight);
            end
            push_word(weight, pick_word(k));
        end
        @(negedge clk);
        drop_valid(weight);
    endtask

    task automatic wait_drain(input int total);
        int t;
        t = 0;
        while (n_out != total || o_sum_valid) begin
            @(negedge clk);
            t++;
            if (t > 4 * TIMEOUT) begin
                describe_error("pipeline did not drain");
            end
        end
    endtask

    // one pair sent two cycles apart with the output free
    task automatic send_split(input bit first_weight);
        push_word(first_weight, pick_word(2));
        @(negedge clk);
        drop_valid(first_weight);
        @(negedge clk);
        push_word(!first_weight, pick_word(2));
        @(negedge clk);
        drop_valid(!first_weight);
        pairs_sent++;
        wait_drain(pairs_sent);
    endtask

    task automatic run_config(input au_mode_e m, input num_type_e inum, input num_type_e wnum,
                              input bit rnd_mask);
        i_mode    = m;
        i_inum    = inum;
        i_wnum    = wnum;
        i_mask    = rnd_mask ? 16'($urandom()) : 16'hffff;
        test_name = $sformatf("%s_%s_%s_%s", m.name(), inum.name(), wnum.name(),
                              rnd_mask ? "rmask" : "full");
        stall_on <= 1'b1;
        fork
            stream_words(1'b0, WORDS);
            stream_words(1'b1, WORDS);
        join
        pairs_sent += WORDS;
        wait_drain(pairs_sent);
        stall_on <= 1'b0;
        lat_chk  <= 1'b1;
        send_split(1'b0);
        send_split(1'b1);
        lat_chk  <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hfa29a2b9));
        i_rst_n      = 1'b0;
        i_en         = 1'b1;
        i_sum_ready  = 1'b1;
        i_mode       = XNOR;
        i_inum       = UNSIGNED;
        i_wnum       = UNSIGNED;
        i_mask       = 16'hffff;
        i_ipix_valid = 1'b0;
        i_ipix       = '0;
        i_wpix_valid = 1'b0;
        i_wpix       = '0;
        stall_on     = 1'b0;
        lat_chk      = 1'b0;
        test_name    = "reset";
        repeat (5) @(negedge clk);
        i_rst_n = 1'b1;
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 4; s++) begin
                for (int r = 0; r < 2; r++) begin
                    run_config(au_mode_e'(m), num_type_e'(s[1]), num_type_e'(s[0]), r == 1);
                end
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/pe_arith_pkg.sv
common/pe_pix_pkg.sv
common/pix_if.sv
hw/operand_unpack.sv
aunit/aunit_addt.sv
aunit/aunit_mac.sv
hw/pe_top.sv
tb/tb_clkgen.sv
tb/tb_pe_top.sv
